// ==== branch_unit.f ====
+incdir+common
common/bru_pkg.sv
rtl/branch_decode.sv
bht/bht_predictor.sv
bru/exu_bru.sv
rtl/branch_unit_top.sv
bench/tb_branch_unit.sv

// ==== Bender.yml ====
package:
  name: branch_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bru_pkg.sv
      - rtl/branch_decode.sv
      - bht/bht_predictor.sv
      - bru/exu_bru.sv
      - rtl/branch_unit_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_branch_unit.sv

// ==== bench/tb_branch_unit.sv ====
// testbench for branch_unit_top with directed and random branch, jump, fence and irq traffic
// a reference model of decode, BHT and resolve predicts every redirect two cycles ahead
// each test prints one result line, a summary line closes the run

`include "bru_config.svh"

module tb_branch_unit;
    timeunit 1ns;
    timeprecision 1ps;

    // instruction counts per test plus two drain slots each
    localparam int total_instr = 48 + 15 + 10 + 10 + 64 + 5 * 2;
    localparam int margin_cycles = 60;  // reset + pipeline + slack

    typedef struct packed {
        logic        flag;
        logic [31:0] addr;
        logic        upd;    // counter write-back expected
        logic        taken;  // resolved outcome for the counter
    } ref_out_t;

    typedef struct packed {
        logic [31:0] due;   // cycle when the output is checked
        logic        flag;
        logic [31:0] addr;
    } exp_t;

    logic           clk_i;
    logic           arst_n_i;
    logic           valid_i;
    bru_pkg::inst_u inst_i;
    logic [31:0]    pc_i;
    logic [31:0]    rs1_i;
    logic [31:0]    rs2_i;
    logic           int_assert_i;
    logic [31:0]    int_addr_i;
    logic           jump_flag_o;
    logic [31:0]    jump_addr_o;

    integer      seed = 32'h74cc_a096;
    logic [31:0] cyc = 0;
    exp_t        exp_q[$];
    logic [1:0]  bht_m[`BHT_ENTRIES];  // model counters
    logic        pend_valid = 1'b0;    // write from the previous instruction
    logic [5:0]  pend_idx;
    logic        pend_taken;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          chk_mark;
    int          err_mark;
    logic [2:0]  f3_tab[6] = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};

    branch_unit_top dut_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o)
    );

    always #4 clk_i = ~clk_i;  // 8 ns period

    always @(posedge clk_i) cyc = cyc + 1;

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // expected redirect from the RV32I rules and the counter value read in stage 1
    function automatic ref_out_t ref_resolve(input logic v, input logic [31:0] inst,
                                             input logic [31:0] pc, input logic [31:0] rs1,
                                             input logic [31:0] rs2, input logic irq,
                                             input logic [31:0] irq_addr,
                                             input logic [1:0] cnt);
        ref_out_t    r;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        cond;
        logic        jal;
        logic        jalr;
        logic        fence;
        logic        taken;
        logic        pred;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_i;
        logic [31:0] target;
        opc   = inst[6:0];
        f3    = inst[14:12];
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_i = {{20{inst[31]}}, inst[31:20]};
        cond  = v && opc == `OPC_BRANCH && f3 != 3'b010 && f3 != 3'b011;
        jal   = v && opc == `OPC_JAL;
        jalr  = v && opc == `OPC_JALR;
        fence = v && opc == `OPC_FENCE;
        case (f3)
            `F3_BEQ:  taken = rs1 == rs2;
            `F3_BNE:  taken = rs1 != rs2;
            `F3_BLT:  taken = $signed(rs1) < $signed(rs2);
            `F3_BGE:  taken = $signed(rs1) >= $signed(rs2);
            `F3_BLTU: taken = rs1 < rs2;
            `F3_BGEU: taken = rs1 >= rs2;
            default:  taken = 1'b0;
        endcase
        taken = taken && cond;
        pred  = cond && cnt >= 2'd2;  // weakly taken or above
        if (jalr) target = rs1 + imm_i;
        else if (jal) target = pc + imm_j;
        else if (fence) target = pc + 32'd4;
        else target = pc + imm_b;
        // wrong or missing prediction, or any unconditional transfer
        r.flag  = irq || jal || jalr || fence || (taken != pred);
        r.addr  = irq ? irq_addr : (pred && !taken) ? pc + 32'd4 : target;
        r.upd   = cond && !irq;
        r.taken = taken;
        return r;
    endfunction

    function automatic logic [1:0] count_step(input logic [1:0] cnt, input logic taken);
        if (taken) return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    // stimulus words built through the union views
    function automatic bru_pkg::inst_u make_branch(input logic [2:0] f3, input logic [12:0] imm);
        bru_pkg::inst_u w;
        w          = '0;
        w.b.opcode  = `OPC_BRANCH;
        w.b.funct3  = f3;
        w.b.rs1     = 5'd1;
        w.b.rs2     = 5'd2;
        w.b.imm12   = imm[12];
        w.b.imm11   = imm[11];
        w.b.imm10_5 = imm[10:5];
        w.b.imm4_1  = imm[4:1];
        return w;
    endfunction

    function automatic bru_pkg::inst_u make_jal(input logic [20:0] imm);
        bru_pkg::inst_u w;
        w           = '0;
        w.j.opcode   = `OPC_JAL;
        w.j.rd       = 5'd1;
        w.j.imm20    = imm[20];
        w.j.imm19_12 = imm[19:12];
        w.j.imm11    = imm[11];
        w.j.imm10_1  = imm[10:1];
        return w;
    endfunction

    function automatic bru_pkg::inst_u make_jalr(input logic [11:0] imm);
        bru_pkg::inst_u w;
        w           = '0;
        w.b.opcode  = `OPC_JALR;
        w.b.rs1     = 5'd1;
        w.b.imm12   = imm[11];  // I immediate sits in the upper b fields
        w.b.imm10_5 = imm[10:5];
        w.b.rs2     = imm[4:0];
        return w;
    endfunction

    function automatic bru_pkg::inst_u make_fence();
        bru_pkg::inst_u w;
        w          = '0;
        w.b.opcode = `OPC_FENCE;
        return w;
    endfunction

    // drive one cycle and queue its expected redirect
    task automatic issue(input logic v, input logic [31:0] inst, input logic [31:0] pc,
                         input logic [31:0] rs1, input logic [31:0] rs2,
                         input logic irq, input logic [31:0] irq_addr);
        ref_out_t   r;
        exp_t       e;
        logic [5:0] idx;
        @(posedge clk_i);
        #1;
        valid_i      = v;
        inst_i       = inst;
        pc_i         = pc;
        rs1_i        = rs1;
        rs2_i        = rs2;
        int_assert_i = irq;
        int_addr_i   = irq_addr;
        idx = pc[`BHT_IDX_LSB +: `BHT_IDX_W];
        r   = ref_resolve(v, inst, pc, rs1, rs2, irq, irq_addr, bht_m[idx]);
        // previous instruction writes on the edge this one is sampled
        if (pend_valid) bht_m[pend_idx] = count_step(bht_m[pend_idx], pend_taken);
        pend_valid = r.upd;
        pend_idx   = idx;
        pend_taken = r.taken;
        e.due  = cyc + 2;
        e.flag = r.flag;
        e.addr = r.addr;
        exp_q.push_back(e);
    endtask

    task automatic idle();
        issue(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic begin_test();
        chk_mark = n_checks;
        err_mark = n_errors;
    endtask

    // flush the pipe, wait for the last check, report
    task automatic end_test(input string name);
        int errs;
        idle();
        idle();
        while (exp_q.size() > 0) @(negedge clk_i);
        errs = n_errors - err_mark;
        n_tests++;
        if (errs != 0) n_failed++;
        $display("test %s: %s (%0d checks, %0d errors)", name, (errs == 0) ? "ok" : "FAILED",
                 n_checks - chk_mark, errs);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin : compare
        exp_t e;
        while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            n_checks++;
            assert (jump_flag_o === e.flag) else begin
                $display("mismatch jump_flag_o: got %h expected %h at cycle %0d",
                         jump_flag_o, e.flag, cyc);
                n_errors++;
            end
            if (e.flag) begin
                assert (jump_addr_o === e.addr) else begin
                    $display("mismatch jump_addr_o: got %h expected %h at cycle %0d",
                             jump_addr_o, e.addr, cyc);
                    n_errors++;
                end
            end
        end
    end

    initial begin : watchdog
        #((total_instr + margin_cycles) * 8);
        $display("watchdog expired before all tests had finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] sel;
        logic        v;
        logic        irq;
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        valid_i      = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        for (int i = 0; i < `BHT_ENTRIES; i++) bht_m[i] = 2'd1;  // weakly not taken
        repeat (3) @(posedge clk_i);
        #1 arst_n_i = 1'b1;

        // all six compares with one fresh counter each
        begin_test();
        for (int f = 0; f < 6; f++) begin
            for (int i = 0; i < 8; i++) begin
                a = next_rand();
                b = (i % 3 == 0) ? a : next_rand();  // some equal pairs
                if (i == 5) b = ~a;                  // opposite signs
                pc = 32'h1000 + 4 * (f * 8 + i);
                issue(1'b1, make_branch(f3_tab[f], next_rand() & 13'h1ffe), pc, a, b,
                      1'b0, 32'h0);
            end
        end
        end_test("compare");

        // train idx 48 to taken, then fall through once
        begin_test();
        for (int i = 0; i < 5; i++) begin
            b = (i == 4) ? 32'd6 : 32'd5;
            issue(1'b1, make_branch(`F3_BEQ, 13'h0040), 32'h20c0, 32'd5, b, 1'b0, 32'h0);
            idle();
            idle();
        end
        end_test("training");

        // unconditional transfers on the weakly taken entry left by training
        begin_test();
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, make_jal(next_rand() & 21'h1ffffe), 32'h30c0, next_rand(),
                  next_rand(), 1'b0, 32'h0);
        end
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, make_jalr(next_rand()), 32'h30c0, next_rand(), next_rand(),
                  1'b0, 32'h0);
        end
        issue(1'b1, make_fence(), 32'h30c0, 32'h0, 32'h0, 1'b0, 32'h0);
        issue(1'b1, make_fence(), 32'h30c4, 32'h0, 32'h0, 1'b0, 32'h0);
        end_test("jumps");

        // irq on a branch, on a bubble and on a jal, then the branch alone
        begin_test();
        issue(1'b1, make_branch(`F3_BNE, 13'h0100), 32'h20c4, 32'd1, 32'd2, 1'b1, 32'h8000_0100);
        idle();
        idle();
        issue(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b1, 32'h8000_0200);
        idle();
        idle();
        issue(1'b1, make_jal(21'h000800), 32'h20c4, 32'h0, 32'h0, 1'b1, 32'h8000_0300);
        idle();
        idle();
        // counter at idx 49 still weakly not taken
        issue(1'b1, make_branch(`F3_BNE, 13'h0100), 32'h20c4, 32'd1, 32'd2, 1'b0, 32'h0);
        end_test("interrupt");

        // back to back mix on 8 aliasing entries
        begin_test();
        for (int i = 0; i < 64; i++) begin
            sel = next_rand() % 8;
            v   = (next_rand() % 8) != 0;
            irq = (next_rand() % 16) == 0;
            pc  = 32'h4000 + (next_rand() % 8) * 4;
            a   = next_rand() % 16;   // small values so equality shows up
            b   = (next_rand() % 2) ? next_rand() % 16 : next_rand();
            case (sel)
                0, 1, 2, 3: issue(v, make_branch(f3_tab[next_rand() % 6], next_rand() & 13'h1ffe),
                                  pc, a, b, irq, next_rand());
                4:       issue(v, make_jal(next_rand() & 21'h1ffffe), pc, a, b, irq, next_rand());
                5:       issue(v, make_jalr(next_rand()), pc, a, b, irq, next_rand());
                6:       issue(v, make_fence(), pc, a, b, irq, next_rand());
                default: issue(v, {next_rand() & 32'hffff_ff80} | 32'h33, pc, a, b,
                               irq, next_rand());  // register ALU op
            endcase
        end
        end_test("random_mix");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== rtl/branch_unit_top.sv ====
// top of the branch unit: decode + BHT read, resolve, redirect register
// redirect leaves 2 clocks after the instruction is presented

`include "bru_config.svh"

module branch_unit_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  bru_pkg::inst_u              inst_i,
    input  logic [`INST_ADDR_WIDTH-1:0] pc_i,
    input  logic [31:0]                 rs1_i,
    input  logic [31:0]                 rs2_i,
    input  logic                        int_assert_i,
    input  logic [`INST_ADDR_WIDTH-1:0] int_addr_i,
    output logic                        jump_flag_o,
    output logic [`INST_ADDR_WIDTH-1:0] jump_addr_o
);
    bru_pkg::bht_pred_t   pred;      // stage 1 read
    bru_pkg::bjp_req_t    req_q;     // stage 1 -> 2
    bru_pkg::redirect_t   redirect;  // stage 2 result
    bru_pkg::bht_update_t bht_upd;   // stage 2 -> table

    logic                        jump_flag_q;
    logic [`INST_ADDR_WIDTH-1:0] jump_addr_q;

    branch_decode u_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .pred_i       (pred),
        .req_o        (req_q)
    );

    // read with the incoming pc, written back from stage 2
    bht_predictor u_bht (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rd_pc_i  (pc_i),
        .pred_o   (pred),
        .upd_i    (bht_upd)
    );

    exu_bru u_bru (
        .req_i      (req_q),
        .redirect_o (redirect),
        .update_o   (bht_upd)
    );

    // stage 3 redirect register
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            jump_flag_q <= 1'b0;
        end else begin
            jump_flag_q <= redirect.jump_flag;
        end
    end

    always_ff @(posedge clk_i) begin
        jump_addr_q <= redirect.jump_addr;  // only meaningful with the flag
    end

    assign jump_flag_o = jump_flag_q;
    assign jump_addr_o = jump_addr_q;

endmodule

// ==== bru/exu_bru.sv ====
// stage 2 branch resolution, purely combinational on the stage 1 packet
// gives the fetch redirect and the BHT write-back

`include "bru_config.svh"

module exu_bru (
    input  bru_pkg::bjp_req_t    req_i,
    output bru_pkg::redirect_t   redirect_o,
    output bru_pkg::bht_update_t update_o
);
    logic                        op1_eq_op2;
    logic                        op1_ge_op2_s;
    logic                        op1_ge_op2_u;
    logic                        is_cond;      // valid conditional branch
    logic                        is_jump;      // JAL or JALR
    logic                        cmp_true;
    logic                        branch_cond;
    logic                        rollback;
    logic [`INST_ADDR_WIDTH-1:0] adder_op2;
    logic [`INST_ADDR_WIDTH-1:0] adder_res;

    // compares on rs1 / rs2
    assign op1_eq_op2   = (req_i.op1 == req_i.op2);
    assign op1_ge_op2_s = $signed(req_i.op1) >= $signed(req_i.op2);
    assign op1_ge_op2_u = req_i.op1 >= req_i.op2;

    assign is_cond = req_i.valid & (req_i.op.beq | req_i.op.bne | req_i.op.blt |
                                    req_i.op.bge | req_i.op.bltu | req_i.op.bgeu);
    assign is_jump = req_i.op.jump | req_i.op.jalr;

    // outcome of whichever compare is selected
    assign cmp_true = (req_i.op.beq  &  op1_eq_op2)   |
                      (req_i.op.bne  & ~op1_eq_op2)   |
                      (req_i.op.blt  & ~op1_ge_op2_s) |
                      (req_i.op.bge  &  op1_ge_op2_s) |
                      (req_i.op.bltu & ~op1_ge_op2_u) |
                      (req_i.op.bgeu &  op1_ge_op2_u);

    // jumps are always taken
    assign branch_cond = req_i.valid & (cmp_true | is_jump);

    // predicted taken but actually falls through
    assign rollback = req_i.is_pred & req_i.valid & ~branch_cond;

    // one adder: target, or pc + 4 on rollback
    assign adder_op2 = rollback ? `INST_ADDR_WIDTH'(4) : req_i.jump_op2;
    assign adder_res = req_i.jump_op1 + adder_op2;  // jump_op1 is pc for rollback

    // predicted-taken branches were already redirected by fetch
    assign redirect_o.jump_flag = req_i.int_assert
                                | (branch_cond & ~req_i.is_pred)
                                | (req_i.valid & req_i.op.fence)
                                | rollback;

    // interrupt wins over any target
    assign redirect_o.jump_addr = req_i.int_assert ? req_i.int_addr : adder_res;

    // counters only track conditional branches, not when interrupted
    assign update_o.valid = is_cond & ~req_i.int_assert;
    assign update_o.pc    = req_i.pc;
    assign update_o.taken = branch_cond & ~is_jump;

endmodule

// ==== bht/bht_predictor.sv ====
// bimodal branch history table of 2-bit saturating counters
// read is combinational by pc, update is written on the clock edge

`include "bru_config.svh"

module bht_predictor (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [`INST_ADDR_WIDTH-1:0] rd_pc_i,
    output bru_pkg::bht_pred_t          pred_o,
    input  bru_pkg::bht_update_t        upd_i
);
    localparam logic [1:0] CNT_WEAK_NT = 2'b01;  // reset state
    localparam logic [1:0] CNT_MAX     = 2'b11;
    localparam logic [1:0] CNT_MIN     = 2'b00;

    logic [1:0]            cnt_q [`BHT_ENTRIES];
    logic [`BHT_IDX_W-1:0] rd_idx;
    logic [`BHT_IDX_W-1:0] upd_idx;
    logic [1:0]            upd_cnt;   // current value at upd_idx
    logic [1:0]            upd_next;

    // word-aligned pc bits pick the entry
    assign rd_idx  = rd_pc_i[`BHT_IDX_LSB +: `BHT_IDX_W];
    assign upd_idx = upd_i.pc[`BHT_IDX_LSB +: `BHT_IDX_W];

    // msb set means 2 or 3, predict taken
    assign pred_o.taken = cnt_q[rd_idx][1];
    assign pred_o.idx   = rd_idx;

    assign upd_cnt = cnt_q[upd_idx];

    // one step toward the outcome, saturating
    always_comb begin
        upd_next = upd_cnt;
        if (upd_i.taken) begin
            if (upd_cnt != CNT_MAX) begin
                upd_next = upd_cnt + 2'd1;
            end
        end else begin
            if (upd_cnt != CNT_MIN) begin
                upd_next = upd_cnt - 2'd1;
            end
        end
    end

    // no read bypass, a write shows up on the next read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                cnt_q[i] <= CNT_WEAK_NT;
            end
        end else if (upd_i.valid) begin
            cnt_q[upd_idx] <= upd_next;
        end
    end

endmodule

// ==== rtl/branch_decode.sv ====
// stage 1 of the branch unit: decode, operand and adder input select
// combines the BHT prediction and registers the request packet

`include "bru_config.svh"

module branch_decode (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        valid_i,
    input  bru_pkg::inst_u              inst_i,
    input  logic [`INST_ADDR_WIDTH-1:0] pc_i,
    input  logic [31:0]                 rs1_i,
    input  logic [31:0]                 rs2_i,
    input  logic                        int_assert_i,
    input  logic [`INST_ADDR_WIDTH-1:0] int_addr_i,
    input  bru_pkg::bht_pred_t          pred_i,
    output bru_pkg::bjp_req_t           req_o
);
    bru_pkg::bjp_op_t            op_d;
    logic                        is_cond_d;   // one of the six compares
    logic [`INST_ADDR_WIDTH-1:0] imm_b;
    logic [`INST_ADDR_WIDTH-1:0] imm_j;
    logic [`INST_ADDR_WIDTH-1:0] imm_i;
    logic [`INST_ADDR_WIDTH-1:0] jump_op1_d;
    logic [`INST_ADDR_WIDTH-1:0] jump_op2_d;

    // control regs, reset
    logic                        valid_q;
    bru_pkg::bjp_op_t            op_q;
    logic                        is_pred_q;
    logic                        int_assert_q;
    // payload regs
    logic [31:0]                 op1_q;
    logic [31:0]                 op2_q;
    logic [`INST_ADDR_WIDTH-1:0] jump_op1_q;
    logic [`INST_ADDR_WIDTH-1:0] jump_op2_q;
    logic [`INST_ADDR_WIDTH-1:0] pc_q;
    logic [`INST_ADDR_WIDTH-1:0] int_addr_q;

    // opcode + funct3, anything else stays a bubble
    always_comb begin
        op_d = '0;
        case (inst_i.b.opcode)
            `OPC_BRANCH: begin
                case (inst_i.b.funct3)
                    `F3_BEQ:  op_d.beq  = 1'b1;
                    `F3_BNE:  op_d.bne  = 1'b1;
                    `F3_BLT:  op_d.blt  = 1'b1;
                    `F3_BGE:  op_d.bge  = 1'b1;
                    `F3_BLTU: op_d.bltu = 1'b1;
                    `F3_BGEU: op_d.bgeu = 1'b1;
                    default:  ;  // 010/011 reserved
                endcase
            end
            `OPC_JAL:   op_d.jump  = 1'b1;
            `OPC_JALR:  op_d.jalr  = 1'b1;
            `OPC_FENCE: op_d.fence = 1'b1;
            default:    ;
        endcase
        if (!valid_i) begin
            op_d = '0;  // no instruction this cycle
        end
    end

    assign is_cond_d = op_d.beq | op_d.bne | op_d.blt | op_d.bge | op_d.bltu | op_d.bgeu;

    // sign-extended immediates from the matching view
    assign imm_b = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
                    inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
    assign imm_j = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
                    inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
    assign imm_i = {{20{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm10_5, inst_i.b.rs2};

    // adder inputs, pc based unless JALR
    always_comb begin
        jump_op1_d = pc_i;
        jump_op2_d = imm_b;  // conditional branches
        if (op_d.jump) begin
            jump_op2_d = imm_j;
        end else if (op_d.jalr) begin
            jump_op1_d = rs1_i;
            jump_op2_d = imm_i;
        end else if (op_d.fence) begin
            jump_op2_d = `INST_ADDR_WIDTH'(4);  // refetch next
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q      <= 1'b0;
            op_q         <= '0;
            is_pred_q    <= 1'b0;
            int_assert_q <= 1'b0;
        end else begin
            valid_q      <= |op_d;
            op_q         <= op_d;
            is_pred_q    <= is_cond_d & pred_i.taken;  // counter >= 2
            int_assert_q <= int_assert_i;              // every cycle
        end
    end

    always_ff @(posedge clk_i) begin
        op1_q      <= rs1_i;
        op2_q      <= rs2_i;
        jump_op1_q <= jump_op1_d;
        jump_op2_q <= jump_op2_d;
        pc_q       <= pc_i;
        int_addr_q <= int_addr_i;
    end

    assign req_o = '{valid: valid_q, op: op_q, op1: op1_q, op2: op2_q,
                     jump_op1: jump_op1_q, jump_op2: jump_op2_q, pc: pc_q,
                     is_pred: is_pred_q, int_assert: int_assert_q,
                     int_addr: int_addr_q};

endmodule

// ==== common/bru_pkg.sv ====
// shared types for the branch unit pipeline
// instruction views, op flags and the packets between stages

`include "bru_config.svh"

package bru_pkg;

    // B-type field layout, also used for the JALR I immediate
    typedef struct packed {
        logic       imm12;    // bit 31, sign
        logic [5:0] imm10_5;
        logic [4:0] rs2;      // imm[4:0] for I-type
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;    // bit 7
        logic [6:0] opcode;
    } inst_b_t;

    // J-type field layout for JAL
    typedef struct packed {
        logic       imm20;    // sign
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    // one word, two decodings
    typedef union packed {
        inst_b_t b;
        inst_j_t j;
    } inst_u;

    // one-hot op flags, all zero for a bubble
    typedef struct packed {
        logic jump;   // JAL
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
        logic jalr;
        logic fence;
    } bjp_op_t;

    // stage 1 -> stage 2
    typedef struct packed {
        logic                        valid;
        bjp_op_t                     op;
        logic [31:0]                 op1;       // rs1, compared
        logic [31:0]                 op2;       // rs2, compared
        logic [`INST_ADDR_WIDTH-1:0] jump_op1;  // adder base
        logic [`INST_ADDR_WIDTH-1:0] jump_op2;  // adder offset
        logic [`INST_ADDR_WIDTH-1:0] pc;
        logic                        is_pred;   // predicted taken
        logic                        int_assert;
        logic [`INST_ADDR_WIDTH-1:0] int_addr;
    } bjp_req_t;

    // fetch redirect
    typedef struct packed {
        logic                        jump_flag;
        logic [`INST_ADDR_WIDTH-1:0] jump_addr;
    } redirect_t;

    // counter write-back
    typedef struct packed {
        logic                        valid;
        logic [`INST_ADDR_WIDTH-1:0] pc;
        logic                        taken;  // resolved outcome
    } bht_update_t;

    // prediction read
    typedef struct packed {
        logic                  taken;  // counter msb
        logic [`BHT_IDX_W-1:0] idx;    // index that was read
    } bht_pred_t;

endpackage

// ==== common/bru_config.svh ====
// fixed widths, BHT geometry and RV32I encodings for the branch unit
// include before any file that uses these macros

`ifndef BRU_CONFIG_SVH
`define BRU_CONFIG_SVH

// pc and target width
`define INST_ADDR_WIDTH 32

// bimodal table, indexed by pc[7:2]
`define BHT_ENTRIES     64
`define BHT_IDX_W       6
`define BHT_IDX_LSB     2

// major opcodes, bits [6:0]
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_FENCE       7'b0001111  // fence, fence.i not split out

// conditional branch funct3, bits [14:12]
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

`endif
